/* list.f */
+incdir+rtl
rtl/amo_pkg.sv
rtl/tcdm_pkg.sv
rtl/amo_alu.sv
rtl/resp_buffer.sv
rtl/amo_ctrl.sv
rtl/tcdm_adapter.sv
verification/tb_tcdm_adapter.sv

/* rtl/amo_alu.sv */
// combinational atomic ALU, combines the old memory word with the captured operand
`timescale 1ns/100ps
`default_nettype none

module amo_alu (
  input  amo_pkg::amo_op_e amo_op_i,
  input  tcdm_pkg::data_t  mem_i,
  input  tcdm_pkg::data_t  operand_i,
  output tcdm_pkg::data_t  result_o
);

  import tcdm_pkg::*;
  import amo_pkg::*;

  logic [alu_width-1:0] op_a;
  logic [alu_width-1:0] op_b;
  logic [alu_width-1:0] sum;
  logic                 sub;
  logic                 is_signed;
  logic                 mem_lt;

  // ------------------------------------------------------------
  // shared adder
  // ------------------------------------------------------------
  assign is_signed = amo_op_i inside {amo_max, amo_min};
  assign sub       = amo_op_i inside {amo_max, amo_maxu, amo_min, amo_minu};

  // sign or zero extension so one extra bit holds the compare result
  assign op_a = is_signed ? {mem_i[$high(mem_i)], mem_i} : {1'b0, mem_i};
  assign op_b = is_signed ? {operand_i[$high(operand_i)], operand_i} : {1'b0, operand_i};

  // two's complement subtract when comparing
  assign sum = op_a + (sub ? ~op_b : op_b) + {{(alu_width - 1){1'b0}}, sub};

  // mem - operand negative means mem is the smaller one
  assign mem_lt = sum[alu_width-1];

  // ------------------------------------------------------------
  // result select
  // ------------------------------------------------------------
  always_comb begin
    case (amo_op_i)
      amo_swap: result_o = operand_i;
      amo_add:  result_o = sum[alu_width-2:0];
      amo_and:  result_o = mem_i & operand_i;
      amo_or:   result_o = mem_i | operand_i;
      amo_xor:  result_o = mem_i ^ operand_i;
      amo_max,
      amo_maxu: result_o = mem_lt ? operand_i : mem_i;
      amo_min,
      amo_minu: result_o = mem_lt ? mem_i : operand_i;
      // not an atomic, leave the word as it was
      default:  result_o = mem_i;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/amo_ctrl.sv */
// request controller of the bank adapter, forwards requests and sequences atomic write-backs
`timescale 1ns/100ps
`default_nettype none

module amo_ctrl #(
  parameter bit register_amo = 1'b0
) (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire                  in_valid_i,
  input  tcdm_pkg::addr_t      in_addr_i,
  input  amo_pkg::amo_op_e     in_amo_i,
  input  wire                  in_write_i,
  input  tcdm_pkg::data_t      in_wdata_i,
  input  tcdm_pkg::be_t        in_be_i,
  input  wire                  resp_stall_i,
  input  tcdm_pkg::data_t      amo_result_i,
  output logic                 in_ready_o,
  output logic                 out_req_o,
  output tcdm_pkg::addr_t      out_addr_o,
  output logic                 out_write_o,
  output tcdm_pkg::data_t      out_wdata_o,
  output tcdm_pkg::be_t        out_be_o,
  output logic                 push_tag_o,
  output logic                 push_data_o,
  output amo_pkg::amo_op_e     amo_op_o,
  output tcdm_pkg::data_t      amo_operand_o
);

  import tcdm_pkg::*;
  import amo_pkg::*;

  amo_state_e state_q, state_d;
  logic       accept;
  logic       is_amo;
  logic       capture;
  logic       push_data_q;
  amo_op_e    amo_op_q;
  addr_t      addr_q;
  data_t      operand_q;
  data_t      result_q;
  data_t      wb_data;

  // ------------------------------------------------------------
  // acceptance
  // ------------------------------------------------------------
  // no new request while a response is stuck or an atomic owns the bank
  assign in_ready_o = (state_q == idle) && !resp_stall_i;
  assign accept     = in_valid_i && in_ready_o;
  assign is_amo     = in_amo_i inside {[amo_swap:amo_minu]};
  assign capture    = accept && is_amo;

  // loads and atomics return the old word
  assign push_tag_o  = accept && (is_amo || !in_write_i);
  assign push_data_o = push_data_q;

  assign amo_op_o      = amo_op_q;
  assign amo_operand_o = operand_q;

  assign wb_data = register_amo ? result_q : amo_result_i;

  // ------------------------------------------------------------
  // SRAM request mux and atomic FSM
  // ------------------------------------------------------------
  always_comb begin
    state_d     = state_q;
    out_req_o   = 1'b1;
    out_write_o = 1'b1;
    out_addr_o  = addr_q;
    out_wdata_o = wb_data;
    out_be_o    = '1;
    case (state_q)
      idle: begin
        // atomics start with a plain read of the old word
        out_req_o   = accept;
        out_write_o = accept && in_write_i && !is_amo;
        out_addr_o  = in_addr_i;
        out_wdata_o = in_wdata_i;
        out_be_o    = in_be_i;
        if (capture) begin
          state_d = do_amo;
        end
      end
      do_amo: begin
        if (register_amo) begin
          // result is only registered here, the bank stays quiet
          out_req_o   = 1'b0;
          out_write_o = 1'b0;
          state_d     = write_back;
        end else begin
          state_d = idle;
        end
      end
      write_back: begin
        state_d = idle;
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= idle;
      push_data_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // read data shows up one cycle after any read request
      push_data_q <= out_req_o && !out_write_o;
    end
  end

  // atomic operands and optional result slice
  always_ff @(posedge clk_i) begin
    if (capture) begin
      amo_op_q  <= in_amo_i;
      addr_q    <= in_addr_i;
      operand_q <= in_wdata_i;
    end
    if (state_q == do_amo) begin
      result_q <= amo_result_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/amo_pkg.sv */
// atomic opcode and adapter state types, imported by the controller, the ALU and the testbench
`default_nettype none

`include "tcdm_macros.svh"

package amo_pkg;

  // width of the shared adder, one extra bit for the compare sign
  localparam int unsigned alu_width = `TCDM_DATA_W + 1;

  // ------------------------------------------------------------
  // atomic opcodes
  // ------------------------------------------------------------
  // codes above amo_minu are handled as plain loads and stores
  typedef enum logic [3:0] {
    amo_none = 4'h0,
    amo_swap = 4'h1,
    amo_add  = 4'h2,
    amo_and  = 4'h3,
    amo_or   = 4'h4,
    amo_xor  = 4'h5,
    amo_max  = 4'h6,
    amo_maxu = 4'h7,
    amo_min  = 4'h8,
    amo_minu = 4'h9
  } amo_op_e;

  // read-modify-write sequencing
  typedef enum logic [1:0] {
    idle       = 2'd0,
    do_amo     = 2'd1,
    write_back = 2'd2
  } amo_state_e;

endpackage

`default_nettype wire

/* rtl/resp_buffer.sv */
// response buffer of the bank adapter, pairs tags with read data and holds them under back-pressure
`timescale 1ns/100ps
`default_nettype none

module resp_buffer (
  input  wire             clk_i,
  input  wire             rst_ni,
  input  wire             push_tag_i,
  input  tcdm_pkg::tag_t  tag_i,
  input  wire             push_data_i,
  input  tcdm_pkg::data_t rdata_i,
  input  wire             in_ready_i,
  output logic            in_valid_o,
  output tcdm_pkg::tag_t  in_tag_o,
  output tcdm_pkg::data_t in_rdata_o,
  output logic            resp_stall_o
);

  import tcdm_pkg::*;

  tag_t       tag_mem [2];
  logic       tag_wr_q;
  logic       tag_rd_q;
  logic [1:0] tag_cnt_q;
  logic       tag_valid;
  logic       data_full_q;
  data_t      data_q;
  logic       data_valid;
  logic       pop;

  // ------------------------------------------------------------
  // response handshake
  // ------------------------------------------------------------
  // read data always arrives after its tag
  assign in_valid_o   = tag_valid && data_valid;
  assign pop          = in_valid_o && in_ready_i;
  assign resp_stall_o = in_valid_o && !in_ready_i;

  // ------------------------------------------------------------
  // tag buffer, two entries
  // ------------------------------------------------------------
  assign tag_valid = (tag_cnt_q != 2'd0);
  assign in_tag_o  = tag_mem[tag_rd_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_wr_q  <= 1'b0;
      tag_rd_q  <= 1'b0;
      tag_cnt_q <= 2'd0;
    end else begin
      if (push_tag_i) begin
        tag_wr_q <= !tag_wr_q;
      end
      if (pop) begin
        tag_rd_q <= !tag_rd_q;
      end
      if (push_tag_i && !pop) begin
        tag_cnt_q <= tag_cnt_q + 2'd1;
      end else if (pop && !push_tag_i) begin
        tag_cnt_q <= tag_cnt_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_tag_i) begin
      tag_mem[tag_wr_q] <= tag_i;
    end
  end

  // ------------------------------------------------------------
  // read data, one entry with fall-through
  // ------------------------------------------------------------
  assign data_valid = data_full_q || push_data_i;
  assign in_rdata_o = data_full_q ? data_q : rdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_full_q <= 1'b0;
    end else if (pop) begin
      data_full_q <= data_full_q && push_data_i;
    end else begin
      data_full_q <= data_full_q || push_data_i;
    end
  end

  // keep the word unless it went straight out
  always_ff @(posedge clk_i) begin
    if (push_data_i && !(pop && !data_full_q)) begin
      data_q <= rdata_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/tcdm_adapter.sv */
// bank adapter top level, place in front of a single-port SRAM that it owns exclusively
`timescale 1ns/100ps
`default_nettype none

module tcdm_adapter #(
  parameter bit register_amo = 1'b0
) (
  input  wire              clk_i,
  input  wire              rst_ni,
  // requester side
  input  wire              in_valid_i,
  output logic             in_ready_o,
  input  tcdm_pkg::addr_t  in_addr_i,
  input  amo_pkg::amo_op_e in_amo_i,
  input  wire              in_write_i,
  input  tcdm_pkg::data_t  in_wdata_i,
  input  tcdm_pkg::be_t    in_be_i,
  input  tcdm_pkg::tag_t   in_tag_i,
  output logic             in_valid_o,
  input  wire              in_ready_i,
  output tcdm_pkg::data_t  in_rdata_o,
  output tcdm_pkg::tag_t   in_tag_o,
  // SRAM side
  output logic             out_req_o,
  output tcdm_pkg::addr_t  out_addr_o,
  output logic             out_write_o,
  output tcdm_pkg::data_t  out_wdata_o,
  output tcdm_pkg::be_t    out_be_o,
  input  tcdm_pkg::data_t  out_rdata_i
);

  import tcdm_pkg::*;
  import amo_pkg::*;

  logic    push_tag;
  logic    push_data;
  logic    resp_stall;
  amo_op_e amo_op;
  data_t   amo_operand;
  data_t   amo_result;

  amo_ctrl #(
    .register_amo(register_amo)
  ) u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_addr_i    (in_addr_i),
    .in_amo_i     (in_amo_i),
    .in_write_i   (in_write_i),
    .in_wdata_i   (in_wdata_i),
    .in_be_i      (in_be_i),
    .resp_stall_i (resp_stall),
    .amo_result_i (amo_result),
    .in_ready_o   (in_ready_o),
    .out_req_o    (out_req_o),
    .out_addr_o   (out_addr_o),
    .out_write_o  (out_write_o),
    .out_wdata_o  (out_wdata_o),
    .out_be_o     (out_be_o),
    .push_tag_o   (push_tag),
    .push_data_o  (push_data),
    .amo_op_o     (amo_op),
    .amo_operand_o(amo_operand)
  );

  // old word comes straight from the SRAM in the do_amo cycle
  amo_alu u_alu (
    .amo_op_i (amo_op),
    .mem_i    (out_rdata_i),
    .operand_i(amo_operand),
    .result_o (amo_result)
  );

  resp_buffer u_resp (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_tag_i  (push_tag),
    .tag_i       (in_tag_i),
    .push_data_i (push_data),
    .rdata_i     (out_rdata_i),
    .in_ready_i  (in_ready_i),
    .in_valid_o  (in_valid_o),
    .in_tag_o    (in_tag_o),
    .in_rdata_o  (in_rdata_o),
    .resp_stall_o(resp_stall)
  );

endmodule

`default_nettype wire

/* rtl/tcdm_macros.svh */
// bank interface widths, included by the packages and the testbench to size their types
`ifndef TCDM_MACROS_SVH
`define TCDM_MACROS_SVH

// ------------------------------------------------------------
// bank interface widths
// ------------------------------------------------------------

// word address as seen by the requester
`define TCDM_ADDR_W 32

// data word, the atomic ALU assumes 32 bits
`define TCDM_DATA_W 32

// one enable per byte of the data word
`define TCDM_BE_W (`TCDM_DATA_W / 8)

// requester metadata returned with each read response
`define TCDM_TAG_W 8

`endif

/* rtl/tcdm_pkg.sv */
// bank interface types shared by the adapter modules and the testbench
`default_nettype none

`include "tcdm_macros.svh"

package tcdm_pkg;

  // word address
  typedef logic [`TCDM_ADDR_W-1:0] addr_t;

  // data word
  typedef logic [`TCDM_DATA_W-1:0] data_t;

  // byte enables
  typedef logic [`TCDM_BE_W-1:0] be_t;

  // requester metadata, passed back unchanged
  typedef logic [`TCDM_TAG_W-1:0] tag_t;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the bank adapter testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_tcdm_adapter \
  && ./obj_dir/Vtb_tcdm_adapter > sim.log 2>&1 \
  || echo "build or simulation did not complete"

cat sim.log 2>/dev/null
grep -qx "TEST RESULT: PASS" sim.log && exit 0 || exit 1

/* verification/tb_tcdm_adapter.sv */
// testbench for the bank adapter, runs directed and random traffic against an SRAM model
`timescale 1ns/100ps
`default_nettype none

`include "tcdm_macros.svh"

module tb_tcdm_adapter;

  import tcdm_pkg::*;
  import amo_pkg::*;

  // store_load 16, byte enables 20, atomics 54, back-pressure 40, random mix 200
  localparam int total_requests = 330;
  localparam int timeout_cycles = total_requests * 8 + 200;

  logic    clk_i;
  logic    rst_ni;
  logic    in_valid_i;
  logic    in_ready_o;
  addr_t   in_addr_i;
  amo_op_e in_amo_i;
  logic    in_write_i;
  data_t   in_wdata_i;
  be_t     in_be_i;
  tag_t    in_tag_i;
  logic    in_valid_o;
  logic    in_ready_i;
  data_t   in_rdata_o;
  tag_t    in_tag_o;
  logic    out_req_o;
  addr_t   out_addr_o;
  logic    out_write_o;
  data_t   out_wdata_o;
  be_t     out_be_o;
  data_t   out_rdata_i;

  data_t sram [256];
  data_t shadow [256];
  data_t exp_data_q [$];
  tag_t  exp_tag_q [$];
  int    seed;
  int    ready_seed;
  logic  random_ready;
  tag_t  next_tag;
  int    checks;
  int    errors;
  int    tests_run;
  int    tests_failed;
  int    test_errors_start;

  tcdm_adapter #(
    .register_amo(1'b0)
  ) uut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_addr_i  (in_addr_i),
    .in_amo_i   (in_amo_i),
    .in_write_i (in_write_i),
    .in_wdata_i (in_wdata_i),
    .in_be_i    (in_be_i),
    .in_tag_i   (in_tag_i),
    .in_valid_o (in_valid_o),
    .in_ready_i (in_ready_i),
    .in_rdata_o (in_rdata_o),
    .in_tag_o   (in_tag_o),
    .out_req_o  (out_req_o),
    .out_addr_o (out_addr_o),
    .out_write_o(out_write_o),
    .out_wdata_o(out_wdata_o),
    .out_be_o   (out_be_o),
    .out_rdata_i(out_rdata_i)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // reference rules
  // ------------------------------------------------------------
  function automatic data_t fill_word(input int idx);
    return (32'(idx) * 32'h0101_0101) ^ 32'hc35a_0f96;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
    data_t res;
    int    b;
    res = old;
    for (b = 0; b < `TCDM_BE_W; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic data_t amo_ref(input logic [3:0] op, input data_t old, input data_t operand);
    case (op)
      4'h1: return operand;
      4'h2: return old + operand;
      4'h3: return old & operand;
      4'h4: return old | operand;
      4'h5: return old ^ operand;
      4'h6: return ($signed(old) > $signed(operand)) ? old : operand;
      4'h7: return (old > operand) ? old : operand;
      4'h8: return ($signed(old) < $signed(operand)) ? old : operand;
      4'h9: return (old < operand) ? old : operand;
      default: return old;
    endcase
  endfunction

  // ------------------------------------------------------------
  // SRAM model with a one-cycle read
  // ------------------------------------------------------------
  always @(posedge clk_i) begin
    if (out_req_o) begin
      if (out_write_o) begin
        sram[out_addr_o[7:0]] <= merge_bytes(sram[out_addr_o[7:0]], out_wdata_o, out_be_o);
      end else begin
        out_rdata_i <= sram[out_addr_o[7:0]];
      end
    end
  end

  always @(posedge clk_i) begin
    if (random_ready) begin
      in_ready_i <= ($random(ready_seed) % 2) != 0;
    end else begin
      in_ready_i <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // scoreboard
  // ------------------------------------------------------------
  // shadow memory follows every accepted request in order
  always @(posedge clk_i) begin : track_accept
    logic [7:0] idx;
    logic [3:0] op;
    if (rst_ni && in_valid_i && in_ready_o) begin
      idx = in_addr_i[7:0];
      op  = in_amo_i;
      if (op >= 4'h1 && op <= 4'h9) begin
        exp_data_q.push_back(shadow[idx]);
        exp_tag_q.push_back(in_tag_i);
        shadow[idx] = amo_ref(op, shadow[idx], in_wdata_i);
      end else if (!in_write_i) begin
        exp_data_q.push_back(shadow[idx]);
        exp_tag_q.push_back(in_tag_i);
      end else begin
        shadow[idx] = merge_bytes(shadow[idx], in_wdata_i, in_be_i);
      end
    end
  end

  always @(posedge clk_i) begin : compare_resp
    data_t exp_d;
    tag_t  exp_t;
    if (rst_ni && in_valid_o && in_ready_i) begin
      if (exp_data_q.size() == 0) begin
        $display("a response with tag %h was popped while none was expected", in_tag_o);
        errors++;
      end else begin
        exp_d = exp_data_q.pop_front();
        exp_t = exp_tag_q.pop_front();
        checks++;
        if (in_rdata_o !== exp_d) begin
          $display("CHECK FAILED in_rdata_o: got %h, expected %h", in_rdata_o, exp_d);
          errors++;
        end
        if (in_tag_o !== exp_t) begin
          $display("CHECK FAILED in_tag_o: got %h, expected %h", in_tag_o, exp_t);
          errors++;
        end
      end
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------
  task automatic check_idle_outputs(input string when);
    checks++;
    if (in_valid_o !== 1'b0) begin
      $display("CHECK FAILED in_valid_o %s: got %h, expected %h", when, in_valid_o, 1'b0);
      errors++;
    end
    if (out_req_o !== 1'b0) begin
      $display("CHECK FAILED out_req_o %s: got %h, expected %h", when, out_req_o, 1'b0);
      errors++;
    end
    if (out_write_o !== 1'b0) begin
      $display("CHECK FAILED out_write_o %s: got %h, expected %h", when, out_write_o, 1'b0);
      errors++;
    end
    if (in_ready_o !== 1'b1) begin
      $display("CHECK FAILED in_ready_o %s: got %h, expected %h", when, in_ready_o, 1'b1);
      errors++;
    end
  endtask

  // returns at the edge where the request was taken
  task automatic issue(input logic wr, input logic [3:0] op, input addr_t addr,
                       input data_t wdata, input be_t be);
    in_valid_i <= 1'b1;
    in_write_i <= wr;
    in_amo_i   <= amo_op_e'(op);
    in_addr_i  <= addr;
    in_wdata_i <= wdata;
    in_be_i    <= be;
    in_tag_i   <= next_tag;
    next_tag = next_tag + 8'd1;
    @(posedge clk_i);
    while (!in_ready_o) begin
      @(posedge clk_i);
    end
    in_valid_i <= 1'b0;
  endtask

  task automatic end_test(input string name);
    int waited;
    waited = 0;
    random_ready = 1'b0;
    while (exp_data_q.size() != 0 && waited < 64) begin
      @(posedge clk_i);
      waited++;
    end
    repeat (3) @(posedge clk_i);
    if (exp_data_q.size() != 0) begin
      $display("%0d responses never arrived in test %s", exp_data_q.size(), name);
      errors++;
      exp_data_q.delete();
      exp_tag_q.delete();
    end
    tests_run++;
    if (errors != test_errors_start) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_errors_start);
    end else begin
      $display("test %s: ok", name);
    end
    test_errors_start = errors;
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin : stimulus
    int         i;
    int         k;
    int         kind;
    addr_t      addr;
    logic [3:0] op;
    data_t      old_val;
    data_t      operand;
    seed         = 32'hfcc9;
    ready_seed   = $random(seed);
    rst_ni       = 1'b0;
    in_valid_i   = 1'b0;
    in_write_i   = 1'b0;
    in_amo_i     = amo_none;
    in_addr_i    = '0;
    in_wdata_i   = '0;
    in_be_i      = '0;
    in_tag_i     = '0;
    in_ready_i   = 1'b1;
    out_rdata_i  = '0;
    random_ready = 1'b0;
    next_tag     = '0;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_errors_start = 0;
    for (i = 0; i < 256; i++) begin
      sram[i]   = fill_word(i);
      shadow[i] = fill_word(i);
    end

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    check_idle_outputs("during reset");
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_idle_outputs("after reset");
    @(posedge clk_i);
    end_test("reset");

    for (i = 0; i < 8; i++) begin
      issue(1'b1, 4'h0, addr_t'(32'h10 + i), data_t'($random(seed)), 4'hf);
    end
    for (i = 0; i < 8; i++) begin
      issue(1'b0, 4'h0, addr_t'(32'h10 + i), '0, 4'hf);
    end
    end_test("store_load");

    // partial enables never reach 4'hf
    for (i = 0; i < 4; i++) begin
      addr = addr_t'(32'h20 + i);
      issue(1'b1, 4'h0, addr, data_t'($random(seed)), 4'hf);
      for (k = 0; k < 3; k++) begin
        issue(1'b1, 4'h0, addr, data_t'($random(seed)), be_t'((i + k * 5) % 15 + 1));
      end
      issue(1'b0, 4'h0, addr, '0, 4'hf);
    end
    end_test("byte_enables");

    for (k = 0; k < 2; k++) begin
      for (i = 1; i <= 9; i++) begin
        addr    = addr_t'(32'h30 + i + k * 16);
        old_val = (k == 0) ? 32'h8000_0010 : 32'h0000_0030;
        operand = (k == 0) ? 32'h0000_0020 : 32'hffff_fff0;
        issue(1'b1, 4'h0, addr, old_val, 4'hf);
        issue(1'b0, 4'(i), addr, operand, 4'hf);
        issue(1'b0, 4'h0, addr, '0, 4'hf);
      end
    end
    end_test("atomics");

    random_ready = 1'b1;
    for (i = 0; i < 40; i++) begin
      addr = addr_t'(32'h50 + $unsigned($random(seed)) % 8);
      if (i % 2 == 0) begin
        issue(1'b0, 4'h0, addr, '0, 4'hf);
      end else begin
        op = 4'(1 + $unsigned($random(seed)) % 9);
        issue(1'b0, op, addr, data_t'($random(seed)), 4'hf);
      end
    end
    end_test("back_pressure");

    random_ready = 1'b1;
    for (i = 0; i < 200; i++) begin
      kind = $unsigned($random(seed)) % 3;
      addr = addr_t'(32'h60 + $unsigned($random(seed)) % 16);
      if (kind == 2) begin
        op = 4'(1 + $unsigned($random(seed)) % 9);
        issue(($random(seed) % 2) != 0, op, addr, data_t'($random(seed)), 4'hf);
      end else begin
        // non-atomic codes including the retired reservation ones
        k  = $unsigned($random(seed)) % 7;
        op = (k == 0) ? 4'h0 : 4'(k + 9);
        issue(kind == 1, op, addr, data_t'($random(seed)), be_t'($random(seed)));
      end
    end
    end_test("random_mix");

    $display("tests: %0d run, %0d failed; checks: %0d; errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
